/* run_sim.sh */
#!/bin/sh
# builds and runs the testbench with Verilator; a nonzero exit status means failure
cd "$(dirname "$0")" &&
verilator --binary -j 0 --top-module mips_pipeline_tb -f sources.f -o mips_pipeline_tb &&
./obj_dir/mips_pipeline_tb ||
{ echo "simulation failed"; exit 1; }

/* source/execute_stage.sv */
// execute with the decode/execute and execute/memory registers; arithmetic wraps without traps
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
    input  wire                     SYS_clk,
    input  wire                     SYS_reset,
    input  wire                     stall,
    input  wire mips_pkg::id_ex_t   id_ex_in,
    output mips_pkg::id_ex_t        id_ex,
    output mips_pkg::ex_mem_t       ex_mem
);
    logic                ex_valid_q;
    mips_pkg::ctrl_t     ex_ctrl_q;
    mips_pkg::word_t     ex_rs_q;
    mips_pkg::word_t     ex_rt_q;
    mips_pkg::word_t     ex_imm_q;
    mips_pkg::reg_addr_t ex_dest_q;

    mips_pkg::word_t     alu_b;
    mips_pkg::word_t     alu_result;
    logic                less_than;

    logic                mem_valid_q;
    logic                mem_reg_write_q;
    logic                mem_read_q;
    logic                mem_write_q;
    mips_pkg::word_t     mem_alu_q;
    mips_pkg::word_t     mem_store_q;
    mips_pkg::reg_addr_t mem_dest_q;

    always_ff @(posedge SYS_clk, posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            ex_valid_q <= 1'b0;
            ex_ctrl_q  <= '0;
        end
        else if (stall)
        begin
            ex_valid_q <= 1'b0;  // bubble while decode holds
            ex_ctrl_q  <= '0;
        end
        else
        begin
            ex_valid_q <= id_ex_in.valid;
            ex_ctrl_q  <= id_ex_in.ctrl;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        ex_rs_q   <= id_ex_in.rs_value;
        ex_rt_q   <= id_ex_in.rt_value;
        ex_imm_q  <= id_ex_in.imm;
        ex_dest_q <= id_ex_in.dest;
    end

    assign alu_b     = ex_ctrl_q.use_imm ? ex_imm_q : ex_rt_q;
    assign less_than = $signed(ex_rs_q) < $signed(alu_b);

    always_comb
    begin
        case (ex_ctrl_q.alu_op)
            mips_pkg::ALU_ADD: alu_result = ex_rs_q + alu_b;
            mips_pkg::ALU_SUB: alu_result = ex_rs_q - alu_b;
            mips_pkg::ALU_AND: alu_result = ex_rs_q & alu_b;
            mips_pkg::ALU_OR:  alu_result = ex_rs_q | alu_b;
            mips_pkg::ALU_SLT: alu_result = mips_pkg::word_t'(less_than);
            default:           alu_result = '0;
        endcase
    end

    always_ff @(posedge SYS_clk, posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            mem_valid_q     <= 1'b0;
            mem_reg_write_q <= 1'b0;
            mem_read_q      <= 1'b0;
            mem_write_q     <= 1'b0;
        end
        else
        begin
            mem_valid_q     <= ex_valid_q;
            mem_reg_write_q <= ex_ctrl_q.reg_write;
            mem_read_q      <= ex_ctrl_q.mem_read;
            mem_write_q     <= ex_ctrl_q.mem_write;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        mem_alu_q   <= alu_result;
        mem_store_q <= ex_rt_q;
        mem_dest_q  <= ex_dest_q;
    end

    assign id_ex = '{
        valid:    ex_valid_q,
        ctrl:     ex_ctrl_q,
        rs_value: ex_rs_q,
        rt_value: ex_rt_q,
        imm:      ex_imm_q,
        dest:     ex_dest_q
    };

    assign ex_mem = '{
        valid:      mem_valid_q,
        reg_write:  mem_reg_write_q,
        mem_read:   mem_read_q,
        mem_write:  mem_write_q,
        alu_result: mem_alu_q,
        store_data: mem_store_q,
        dest:       mem_dest_q
    };

endmodule

`default_nettype wire

/* source/fetch_decode_stage.sv */
// fetch and decode; branches resolve here with no delay slot, the wrong-path fetch becomes a bubble
`timescale 1ns/10ps
`default_nettype none

module fetch_decode_stage (
    input  wire                        SYS_clk,
    input  wire                        SYS_reset,
    input  wire mips_pkg::word_t       imem_data,
    input  wire                        stall,
    input  wire mips_pkg::reg_write_t  mem_fwd,
    input  wire mips_pkg::reg_write_t  wb_write,
    output mips_pkg::word_t            pc,
    output mips_pkg::id_ex_t           id_ex,
    output mips_pkg::reg_src_t         rs_used,
    output mips_pkg::reg_src_t         rt_used
);
    mips_pkg::word_t     pc_q;
    logic                if_valid;
    mips_pkg::word_t     if_instr;
    mips_pkg::word_t     if_pc;

    mips_pkg::opcode_e   opcode;
    mips_pkg::funct_e    funct;
    mips_pkg::reg_addr_t rs_addr;
    mips_pkg::reg_addr_t rt_addr;
    mips_pkg::reg_addr_t rd_addr;
    mips_pkg::word_t     imm;
    mips_pkg::word_t     pc_plus4;
    mips_pkg::word_t     rf_rs;
    mips_pkg::word_t     rf_rt;
    mips_pkg::word_t     rs_value;
    mips_pkg::word_t     rt_value;

    mips_pkg::ctrl_t     ctrl;
    logic                uses_rs;
    logic                uses_rt;
    logic                dest_rd;
    logic                is_beq;
    logic                is_bne;
    logic                is_jump;
    logic                operands_equal;
    logic                redirect;
    mips_pkg::word_t     target;

    always_ff @(posedge SYS_clk, posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            pc_q     <= mips_pkg::RESET_PC;
            if_valid <= 1'b0;
        end
        else if (!stall)
        begin
            pc_q     <= redirect ? target : pc_q + 32'd4;
            if_valid <= !redirect;  // squash the wrong-path fetch
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        if (!stall)
        begin
            if_instr <= imem_data;
            if_pc    <= pc_q;
        end
    end

    assign opcode   = mips_pkg::opcode_e'(if_instr[31:26]);
    assign funct    = mips_pkg::funct_e'(if_instr[5:0]);
    assign rs_addr  = if_instr[25:21];
    assign rt_addr  = if_instr[20:16];
    assign rd_addr  = if_instr[15:11];
    assign imm      = {{16{if_instr[15]}}, if_instr[15:0]};
    assign pc_plus4 = if_pc + 32'd4;

    always_comb
    begin
        ctrl    = '0;
        uses_rs = 1'b0;
        uses_rt = 1'b0;
        dest_rd = 1'b0;
        is_beq  = 1'b0;
        is_bne  = 1'b0;
        is_jump = 1'b0;
        if (if_valid)
        begin
            case (opcode)
                mips_pkg::OP_RTYPE:
                begin
                    uses_rs        = 1'b1;
                    uses_rt        = 1'b1;
                    dest_rd        = 1'b1;
                    ctrl.reg_write = 1'b1;
                    case (funct)
                        mips_pkg::FN_ADD: ctrl.alu_op = mips_pkg::ALU_ADD;
                        mips_pkg::FN_SUB: ctrl.alu_op = mips_pkg::ALU_SUB;
                        mips_pkg::FN_AND: ctrl.alu_op = mips_pkg::ALU_AND;
                        mips_pkg::FN_OR:  ctrl.alu_op = mips_pkg::ALU_OR;
                        mips_pkg::FN_SLT: ctrl.alu_op = mips_pkg::ALU_SLT;
                        default:          ctrl.reg_write = 1'b0;  // unknown funct, nop
                    endcase
                end
                mips_pkg::OP_ADDI:
                begin
                    uses_rs        = 1'b1;
                    ctrl.reg_write = 1'b1;
                    ctrl.use_imm   = 1'b1;
                end
                mips_pkg::OP_LW:
                begin
                    uses_rs        = 1'b1;
                    ctrl.reg_write = 1'b1;
                    ctrl.mem_read  = 1'b1;
                    ctrl.use_imm   = 1'b1;
                end
                mips_pkg::OP_SW:
                begin
                    uses_rs        = 1'b1;
                    uses_rt        = 1'b1;  // store data read in decode
                    ctrl.mem_write = 1'b1;
                    ctrl.use_imm   = 1'b1;
                end
                mips_pkg::OP_BEQ:
                begin
                    uses_rs = 1'b1;
                    uses_rt = 1'b1;
                    is_beq  = 1'b1;
                end
                mips_pkg::OP_BNE:
                begin
                    uses_rs = 1'b1;
                    uses_rt = 1'b1;
                    is_bne  = 1'b1;
                end
                mips_pkg::OP_J:   is_jump = 1'b1;
                default:          is_jump = 1'b0;  // undefined opcode runs as a nop
            endcase
        end
    end

    register_file i_register_file (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .rs_addr   (rs_addr),
        .rt_addr   (rt_addr),
        .rs_data   (rf_rs),
        .rt_data   (rf_rt),
        .wb_write  (wb_write)
    );

    // memory stage is younger than the writeback path inside the register file
    assign rs_value = (mem_fwd.valid && mem_fwd.dest == rs_addr) ? mem_fwd.data : rf_rs;
    assign rt_value = (mem_fwd.valid && mem_fwd.dest == rt_addr) ? mem_fwd.data : rf_rt;

    assign operands_equal = (rs_value == rt_value);
    assign redirect = !stall &&
                      ((is_beq && operands_equal) || (is_bne && !operands_equal) || is_jump);
    assign target   = is_jump ? {pc_plus4[31:28], if_instr[25:0], 2'b00}
                              : pc_plus4 + {imm[29:0], 2'b00};

    assign pc = pc_q;

    assign id_ex = '{
        valid:    if_valid,
        ctrl:     ctrl,
        rs_value: rs_value,
        rt_value: rt_value,
        imm:      imm,
        dest:     dest_rd ? rd_addr : rt_addr
    };

    assign rs_used = '{used: uses_rs, addr: rs_addr};
    assign rt_used = '{used: uses_rt, addr: rt_addr};

endmodule

`default_nettype wire

/* source/hazard_unit.sv */
// combinational stall check; assumes only memory-stage ALU results are forwarded to decode
`timescale 1ns/10ps
`default_nettype none

module hazard_unit (
    input  wire mips_pkg::reg_src_t  rs_used,
    input  wire mips_pkg::reg_src_t  rt_used,
    input  wire mips_pkg::id_ex_t    id_ex,
    input  wire mips_pkg::ex_mem_t   ex_mem,
    output logic                     stall
);
    function automatic logic src_conflict(
        input mips_pkg::reg_src_t src,
        input mips_pkg::id_ex_t   ex,
        input mips_pkg::ex_mem_t  mem
    );
        logic exe_hit;
        logic load_hit;
        begin
            // result not computed yet
            exe_hit  = ex.valid && ex.ctrl.reg_write && (ex.dest == src.addr);
            // load data only exists after the memory read
            load_hit = mem.valid && mem.mem_read && (mem.dest == src.addr);
            return src.used && (src.addr != '0) && (exe_hit || load_hit);
        end
    endfunction

    logic rs_conflict;
    logic rt_conflict;

    assign rs_conflict = src_conflict(rs_used, id_ex, ex_mem);
    assign rt_conflict = src_conflict(rt_used, id_ex, ex_mem);

    assign stall = rs_conflict || rt_conflict;

endmodule

`default_nettype wire

/* source/memory_writeback_stage.sv */
// word-wide data memory indexed by address bits [9:2]; low bits ignored, contents not reset
`timescale 1ns/10ps
`default_nettype none

module memory_writeback_stage (
    input  wire                      SYS_clk,
    input  wire                      SYS_reset,
    input  wire mips_pkg::ex_mem_t   ex_mem,
    output mips_pkg::reg_write_t     mem_fwd,
    output mips_pkg::reg_write_t     wb_write
);
    mips_pkg::word_t                       dmem [mips_pkg::DMEM_WORDS];
    logic [mips_pkg::DMEM_ADDR_W-1:0]      dmem_index;
    mips_pkg::word_t                       load_data;
    logic                                  writes_reg;

    logic                                  wb_valid_q;
    mips_pkg::reg_addr_t                   wb_dest_q;
    mips_pkg::word_t                       wb_data_q;

    assign dmem_index = ex_mem.alu_result[mips_pkg::DMEM_ADDR_W+1:2];

    always_ff @(posedge SYS_clk)
    begin
        if (ex_mem.valid && ex_mem.mem_write)
            dmem[dmem_index] <= ex_mem.store_data;
    end

    assign load_data  = dmem[dmem_index];  // asynchronous read
    assign writes_reg = ex_mem.valid && ex_mem.reg_write && (ex_mem.dest != '0);

    always_ff @(posedge SYS_clk, posedge SYS_reset)
    begin
        if (SYS_reset)
            wb_valid_q <= 1'b0;
        else
            wb_valid_q <= writes_reg;  // r0 writes dropped here
    end

    always_ff @(posedge SYS_clk)
    begin
        wb_dest_q <= ex_mem.dest;
        wb_data_q <= ex_mem.mem_read ? load_data : ex_mem.alu_result;
    end

    // loaded data is not ready in time for decode, hazard unit stalls instead
    assign mem_fwd = '{
        valid: writes_reg && !ex_mem.mem_read,
        dest:  ex_mem.dest,
        data:  ex_mem.alu_result
    };

    assign wb_write = '{valid: wb_valid_q, dest: wb_dest_q, data: wb_data_q};

endmodule

`default_nettype wire

/* source/mips_pipeline.sv */
// five-stage MIPS subset core; instruction memory is external and must answer combinationally
`timescale 1ns/10ps
`default_nettype none

module mips_pipeline (
    input  wire                   SYS_clk,
    input  wire                   SYS_reset,
    input  wire mips_pkg::word_t  imem_data,
    output mips_pkg::word_t       imem_addr,
    output mips_pkg::reg_write_t  reg_write
);
    mips_pkg::id_ex_t     id_ex_dec;   // leaving decode
    mips_pkg::id_ex_t     id_ex_exe;   // held in execute
    mips_pkg::ex_mem_t    ex_mem;
    mips_pkg::reg_write_t mem_fwd;
    mips_pkg::reg_write_t wb_write;
    mips_pkg::reg_src_t   rs_used;
    mips_pkg::reg_src_t   rt_used;
    logic                 stall;

    fetch_decode_stage i_fetch_decode_stage (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .imem_data (imem_data),
        .stall     (stall),
        .mem_fwd   (mem_fwd),
        .wb_write  (wb_write),
        .pc        (imem_addr),
        .id_ex     (id_ex_dec),
        .rs_used   (rs_used),
        .rt_used   (rt_used)
    );

    hazard_unit i_hazard_unit (
        .rs_used (rs_used),
        .rt_used (rt_used),
        .id_ex   (id_ex_exe),
        .ex_mem  (ex_mem),
        .stall   (stall)
    );

    execute_stage i_execute_stage (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .stall     (stall),
        .id_ex_in  (id_ex_dec),
        .id_ex     (id_ex_exe),
        .ex_mem    (ex_mem)
    );

    memory_writeback_stage i_memory_writeback_stage (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .ex_mem    (ex_mem),
        .mem_fwd   (mem_fwd),
        .wb_write  (wb_write)
    );

    assign reg_write = wb_write;  // one-cycle commit strobe

endmodule

`default_nettype wire

/* source/mips_pkg.sv */
// shared MIPS subset definitions; opcodes outside the listed enums decode as no-ops
`default_nettype none

package mips_pkg;

    localparam int WORD_W      = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int DMEM_WORDS  = 256;
    localparam int DMEM_ADDR_W = $clog2(DMEM_WORDS);

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam word_t RESET_PC = 32'h0040_0000;  // start of user text segment

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } alu_op_e;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    use_imm;   // second ALU operand is the immediate
        alu_op_e alu_op;
    } ctrl_t;

    // source register request from decode to the hazard check
    typedef struct packed {
        logic      used;
        reg_addr_t addr;
    } reg_src_t;

    typedef struct packed {
        logic      valid;
        ctrl_t     ctrl;
        word_t     rs_value;
        word_t     rt_value;
        word_t     imm;      // sign extended
        reg_addr_t dest;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        word_t     alu_result;
        word_t     store_data;
        reg_addr_t dest;
    } ex_mem_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t dest;
        word_t     data;
    } reg_write_t;

endpackage

`default_nettype wire

/* source/register_file.sv */
// 32 x 32 register file, combinational reads with write-through, r0 hardwired to zero
`timescale 1ns/10ps
`default_nettype none

module register_file (
    input  wire                          SYS_clk,
    input  wire                          SYS_reset,
    input  wire mips_pkg::reg_addr_t     rs_addr,
    input  wire mips_pkg::reg_addr_t     rt_addr,
    output mips_pkg::word_t              rs_data,
    output mips_pkg::word_t              rt_data,
    input  wire mips_pkg::reg_write_t    wb_write
);
    mips_pkg::word_t regs [32];

    always_ff @(posedge SYS_clk, posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wb_write.valid && wb_write.dest != '0)  // r0 never written
        begin
            regs[wb_write.dest] <= wb_write.data;
        end
    end

    // a write landing this cycle is seen by decode right away
    assign rs_data = (rs_addr == '0) ? '0 :
                     (wb_write.valid && wb_write.dest == rs_addr) ? wb_write.data :
                     regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 :
                     (wb_write.valid && wb_write.dest == rt_addr) ? wb_write.data :
                     regs[rt_addr];

endmodule

`default_nettype wire

/* sources.f */
source/mips_pkg.sv
source/register_file.sv
source/hazard_unit.sv
source/fetch_decode_stage.sv
source/execute_stage.sv
source/memory_writeback_stage.sv
source/mips_pipeline.sv
verification/mips_pipeline_tb.sv

/* verification/mips_pipeline_tb.sv */
// needs verification/program_golden.txt relative to the run directory; fetch answers within the cycle
`timescale 1ns/10ps
`default_nettype none

module mips_pipeline_tb;

    logic                 SYS_clk;
    logic                 SYS_reset;
    mips_pkg::word_t      imem_data;
    mips_pkg::word_t      imem_addr;
    mips_pkg::reg_write_t reg_write;

    mips_pkg::word_t      imem [$];      // program, index 0 sits at RESET_PC
    mips_pkg::word_t      exp_dest [$];
    mips_pkg::word_t      exp_data [$];
    int                   prog_len;
    int                   exp_count;
    int                   exp_idx;       // next expected write
    logic                 loaded;

    mips_pipeline i_mips_pipeline (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .imem_data (imem_data),
        .imem_addr (imem_addr),
        .reg_write (reg_write)
    );

    always #4 SYS_clk = ~SYS_clk;  // 8 ns period

    task automatic abort_run(input string reason);
        begin
            $display("%s", reason);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    task automatic compare_value(input string name, input mips_pkg::word_t actual,
                                 input mips_pkg::word_t expected);
        begin
            if (actual !== expected)
                abort_run($sformatf("Error: %s = 0x%h, expected 0x%h",
                                    name, actual, expected));
        end
    endtask

    // tokens other than the I and W tags are skipped, so trailing comments are harmless
    task automatic load_golden();
        int              fd;
        int              n;
        string           tok;
        mips_pkg::word_t a;
        mips_pkg::word_t b;
        begin
            fd = $fopen("verification/program_golden.txt", "r");
            if (fd == 0)
                abort_run("could not open verification/program_golden.txt");
            else
            begin
                while ($fscanf(fd, "%s", tok) == 1)
                begin
                    if (tok == "I")
                    begin
                        n = $fscanf(fd, "%h", a);
                        if (n == 1)
                            imem.push_back(a);
                    end
                    else if (tok == "W")
                    begin
                        n = $fscanf(fd, "%h %h", a, b);
                        if (n == 2)
                        begin
                            exp_dest.push_back(a);
                            exp_data.push_back(b);
                        end
                    end
                end
                $fclose(fd);
            end
        end
    endtask

    function automatic mips_pkg::word_t fetch_word(input mips_pkg::word_t addr);
        mips_pkg::word_t offset;
        int              index;
        begin
            offset = addr - mips_pkg::RESET_PC;
            index  = int'(offset >> 2);
            if (index >= 0 && index < prog_len)
                return imem[index];
            else
                return '0;  // outside the program reads as a nop
        end
    endfunction

    task automatic check_write(input mips_pkg::reg_write_t wr);
        begin
            if (exp_idx >= exp_count)
                abort_run($sformatf("unexpected register write to r%0d after the last one",
                                    wr.dest));
            else
            begin
                compare_value("reg_write.dest", mips_pkg::word_t'(wr.dest), exp_dest[exp_idx]);
                compare_value("reg_write.data", wr.data, exp_data[exp_idx]);
                exp_idx++;
            end
        end
    endtask

    // instruction memory model, driven just after the edge
    always @(posedge SYS_clk)
    begin
        #1;
        imem_data = fetch_word(imem_addr);
    end

    // flops settle long before the falling edge
    always @(negedge SYS_clk)
    begin
        if (loaded && !SYS_reset && reg_write.valid)
            check_write(reg_write);
    end

    initial
    begin
        SYS_clk      = 1'b0;
        SYS_reset    = 1'b1;
        imem_data    = '0;
        exp_idx      = 0;
        loaded       = 1'b0;
        load_golden();
        prog_len  = imem.size();
        exp_count = exp_dest.size();
        if (prog_len == 0 || exp_count == 0)
            abort_run("golden file holds no program words or no expected writes");
        else
        begin
            loaded = 1'b1;
            repeat (8) @(posedge SYS_clk);
            #1;
            compare_value("imem_addr", imem_addr, mips_pkg::RESET_PC);  // reset vector
            compare_value("reg_write.valid", mips_pkg::word_t'(reg_write.valid), '0);
            SYS_reset = 1'b0;
            wait (exp_idx == exp_count);
            repeat (20) @(posedge SYS_clk);  // stray writes would show up here
            $display("TB PASSED");
            $finish;
        end
    end

    // watchdog sized from the program length
    initial
    begin
        wait (loaded);
        repeat (prog_len * 30) @(posedge SYS_clk);
        abort_run($sformatf("timeout with %0d of %0d register writes seen",
                            exp_idx, exp_count));
    end

endmodule

`default_nettype wire

/* verification/program_golden.txt */
// tag-I lines hold one program word in hex, listed from address 0x00400000 upward
// tag-W lines hold one expected register write in order: dest then data, both hex
I 20010005 // addi $1, $0, 5
I 2002fffd // addi $2, $0, -3
I 00221820 // add  $3, $1, $2    stalls on $2
I 00222022 // sub  $4, $1, $2
I 0041282a // slt  $5, $2, $1    negative operand
I 0022302a // slt  $6, $1, $2
I 00223824 // and  $7, $1, $2
I 00224025 // or   $8, $1, $2
I 20097fff // addi $9, $0, 0x7fff
I 00495020 // add  $10, $2, $9   wraps past 2^32
I ac0a0008 // sw   $10, 8($0)
I 8c0b0008 // lw   $11, 8($0)
I 01616020 // add  $12, $11, $1  load-use stall
I 200d0005 // addi $13, $0, 5
I 11a10001 // beq  $13, $1, +1   taken on forwarded $13
I 200e0063 // addi $14, $0, 99   skipped
I 14220001 // bne  $1, $2, +1    taken
I 200e0062 // addi $14, $0, 98   skipped
I 10220001 // beq  $1, $2, +1    falls through
I 200f0007 // addi $15, $0, 7
I 142d0001 // bne  $1, $13, +1   falls through
I 20100008 // addi $16, $0, 8
I 08100018 // j    0x00400060
I 20110001 // addi $17, $0, 1    skipped
I 20000009 // addi $0, $0, 9     no write
I 00019020 // add  $18, $0, $1
I 0810001a // j    0x00400068    spins here
W 01 00000005
W 02 fffffffd
W 03 00000002
W 04 00000008
W 05 00000001
W 06 00000000
W 07 00000005
W 08 fffffffd
W 09 00007fff
W 0a 00007ffc
W 0b 00007ffc
W 0c 00008001
W 0d 00000005
W 0f 00000007
W 10 00000008
W 12 00000005
